// File: verilog/mant_mult_defines.svh
//////////////////////////////////////////////////////////////////////
// Widths for the single-precision mantissa multiplier
// NUM_PP and PP_W hold only for an even MANT_W
//////////////////////////////////////////////////////////////////////
`ifndef MANT_MULT_DEFINES_SVH
`define MANT_MULT_DEFINES_SVH

// Mantissa incl. hidden bit
`define MANT_W 24

// Radix-4 rows
// One per bit pair plus one for the zero pad on top
`define NUM_PP ((`MANT_W / 2) + 1)

// One partial product incl. sign extension bits
`define PP_W ((2 * `MANT_W) + 1)

// Unsigned product
`define PROD_W (2 * `MANT_W)

`endif

// File: verilog/mant_mult_pkg.sv
//////////////////////////////////////////////////////////////////////
// Payload types of the mantissa multiplier pipeline
//////////////////////////////////////////////////////////////////////

`include "mant_mult_defines.svh"

package mant_mult_pkg;

  // One mantissa incl. hidden bit
  typedef logic [`MANT_W-1:0] mant_t;

  // All Booth rows in one packed vector
  // Row i sits in element i, already shifted to weight 4^i
  typedef logic [`NUM_PP-1:0][`PP_W-1:0] pp_array_t;

  // Result of the unsigned multiply
  typedef logic [`PROD_W-1:0] prod_t;

endpackage

// File: verilog/booth_row.sv
//////////////////////////////////////////////////////////////////////
// One radix-4 Booth row; negative rows come out as one's complement
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

`include "mant_mult_defines.svh"

module booth_row
(
  input  logic [2:0]           triplet, // {b[2j+1], b[2j], b[2j-1]}
  input  mant_mult_pkg::mant_t mant_a,
  output logic [`MANT_W:0]     row,     // Selected multiple of a
  output logic                 neg      // Caller adds the hot one
);

  logic               sel_1x;
  logic               sel_2x;
  logic [`MANT_W+1:0] a_ext;  // a with a zero below and above

  //////////////////////////////////////////////////////////////////////
  // Booth decode
  //////////////////////////////////////////////////////////////////////

  assign sel_1x = triplet[1] ^ triplet[0];                  // 001 010 101 110
  assign sel_2x = (triplet[2] & ~triplet[1] & ~triplet[0]) | // 100 is -2x
                  (~triplet[2] & triplet[1] & triplet[0]);   // 011 is +2x

  // Top bit sets the sign
  // 111 yields ~0 plus the hot one which wraps to zero
  assign neg = triplet[2];

  assign a_ext = {1'b0, mant_a, 1'b0};

  //////////////////////////////////////////////////////////////////////
  // Multiple selection
  //////////////////////////////////////////////////////////////////////

  // Bit k takes a[k] for 1x and a[k-1] for 2x
  genvar k;
  generate
    for (k = 0; k <= `MANT_W; k++)
    begin : g_bit
      assign row[k] = ((sel_1x & a_ext[k+1]) | (sel_2x & a_ext[k])) ^ neg;
    end
  endgenerate

endmodule

// File: verilog/pp_generation.sv
//////////////////////////////////////////////////////////////////////
// Booth partial products of two unsigned mantissas
// Rows sum to a*b only modulo 2^PP_W
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

`include "mant_mult_defines.svh"

module pp_generation
(
  input  mant_mult_pkg::mant_t     mant_a,
  input  mant_mult_pkg::mant_t     mant_b,
  output mant_mult_pkg::pp_array_t pp
);

  logic [`MANT_W+2:0] b_ext;                // Zero pad for the triplets
  logic [`MANT_W:0]   booth_pp [`NUM_PP];   // Raw rows before placement
  logic [`NUM_PP-1:0] neg;                  // Sign of each row

  //////////////////////////////////////////////////////////////////////
  // Booth encoding and selection
  //////////////////////////////////////////////////////////////////////

  // One zero below for b[-1]
  // Two on top so the last triplet is never negative
  assign b_ext = {2'b00, mant_b, 1'b0};

  genvar i;
  generate
    for (i = 0; i < `NUM_PP; i++)
    begin : g_row
      booth_row booth_row_i
      (
        .triplet (b_ext[2*i+2 -: 3]),   // b[2i+1:2i-1]
        .mant_a  (mant_a),
        .row     (booth_pp[i]),
        .neg     (neg[i])
      );
    end
  endgenerate

  //////////////////////////////////////////////////////////////////////
  // Sign extension and hot ones
  //////////////////////////////////////////////////////////////////////

  // Each signed row needs ~s at its bit 25 plus a constant
  // The constants of all rows fold into the ones below
  // Row 0 takes {~s, s, s} in place of {1, ~s}
  assign pp[0] = {{(`PP_W - `MANT_W - 4){1'b0}},
                  ~neg[0], neg[0], neg[0],
                  booth_pp[0]};

  // Row i layout before the shift by 2i-2
  //   bit 0       hot one of row i-1
  //   bit 1       zero
  //   bits 2..26  Booth row i
  //   bit 27      inverted sign
  //   bit 28      leading one
  generate
    for (i = 1; i < `NUM_PP; i++)
    begin : g_place
      logic [`PP_W-1:0] row_ext;

      assign row_ext = {{(`PP_W - `MANT_W - 5){1'b0}},
                        1'b1, ~neg[i],
                        booth_pp[i],
                        1'b0, neg[i-1]};

      // Last row is never negative
      // Its leading one and ~s fall off above bit 48
      assign pp[i] = row_ext << (2 * i - 2);
    end
  endgenerate

endmodule

// File: verilog/pp_reduction.sv
//////////////////////////////////////////////////////////////////////
// Carry-save tree 13 to 2 then one carry-propagate add
// Arithmetic is modulo 2^PP_W; top sum bit is zero for unsigned inputs
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

`include "mant_mult_defines.svh"

module pp_reduction
(
  input  mant_mult_pkg::pp_array_t pp,
  output mant_mult_pkg::prod_t     product
);

  // Rows left after lvl levels of 3:2 compressors
  function automatic int rows_at(input int lvl);
    int n;
    n = `NUM_PP;
    for (int l = 0; l < lvl; l++)
    begin
      n = 2 * (n / 3) + (n % 3);  // Groups of three become two
    end
    return n;
  endfunction

  // Levels needed to get down to a sum and a carry row
  function automatic int csa_levels(input int rows);
    int n;
    int lvls;
    n    = rows;
    lvls = 0;
    while (n > 2)
    begin
      n    = 2 * (n / 3) + (n % 3);
      lvls = lvls + 1;
    end
    return lvls;
  endfunction

  localparam int NUM_LVL = csa_levels(`NUM_PP); // 13 9 6 4 3 2

  // Rows per level
  // Slots above the live row count are tied to zero
  logic [`PP_W-1:0] lvl_row [NUM_LVL+1][`NUM_PP];

  genvar l;
  genvar g;
  genvar k;
  genvar r;

  //////////////////////////////////////////////////////////////////////
  // Compressor levels
  //////////////////////////////////////////////////////////////////////

  generate
    for (r = 0; r < `NUM_PP; r++)
    begin : g_in
      assign lvl_row[0][r] = pp[r];
    end

    for (l = 0; l < NUM_LVL; l++)
    begin : g_lvl
      localparam int N_IN  = rows_at(l);
      localparam int N_GRP = N_IN / 3;
      localparam int N_OUT = rows_at(l + 1);

      // Rows 3g..3g+2 in, rows 2g and 2g+1 out
      for (g = 0; g < N_GRP; g++)
      begin : g_csa
        logic [`PP_W-1:0] x;
        logic [`PP_W-1:0] y;
        logic [`PP_W-1:0] z;

        assign x = lvl_row[l][3*g];
        assign y = lvl_row[l][3*g+1];
        assign z = lvl_row[l][3*g+2];

        for (k = 0; k < `PP_W; k++)
        begin : g_sum
          assign lvl_row[l+1][2*g][k] = x[k] ^ y[k] ^ z[k]; // Same weight
        end

        // Carry moves one bit up; the one out of bit 48 is dropped
        assign lvl_row[l+1][2*g+1][0] = 1'b0;
        for (k = 1; k < `PP_W; k++)
        begin : g_cry
          assign lvl_row[l+1][2*g+1][k] = (x[k-1] & y[k-1]) |
                                          (x[k-1] & z[k-1]) |
                                          (y[k-1] & z[k-1]);
        end
      end

      // Leftover rows skip this level
      for (r = 0; r < N_IN - 3 * N_GRP; r++)
      begin : g_pass
        assign lvl_row[l+1][2*N_GRP+r] = lvl_row[l][3*N_GRP+r];
      end

      for (r = N_OUT; r < `NUM_PP; r++)
      begin : g_zero
        assign lvl_row[l+1][r] = '0;
      end
    end
  endgenerate

  //////////////////////////////////////////////////////////////////////
  // Final addition
  //////////////////////////////////////////////////////////////////////

  // Bit 48 of the sum is always zero here
  assign product = mant_mult_pkg::prod_t'(lvl_row[NUM_LVL][0] + lvl_row[NUM_LVL][1]);

endmodule

// File: verilog/pipe_stage.sv
//////////////////////////////////////////////////////////////////////
// Single valid/ready register; in_ready depends on out_ready
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module pipe_stage #(
  parameter type payload_t = logic
)
(
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     valid_q;  // Stage holds an item
  payload_t data_q;

  // Free when empty or when the held item leaves this cycle
  assign in_ready = ~valid_q | out_ready;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= 1'b0;
    end
    else if (in_ready)
    begin
      valid_q <= in_valid;  // Refill, replace or drain
    end
  end

  // Payload loads only on an input transfer
  always_ff @(posedge clk)
  begin
    if (in_valid && in_ready)
    begin
      data_q <= in_data;
    end
  end

  assign out_valid = valid_q;
  assign out_data  = data_q;

  // Stalled output keeps item and data until taken
  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

  // Empty right after reset
  a_reset_empty: assert property (@(posedge clk) rst |=> !out_valid);

endmodule

// File: verilog/mant_mult.sv
//////////////////////////////////////////////////////////////////////
// Unsigned 24x24 mantissa multiplier, two stalling pipeline stages
// Result appears two accepted edges after its operands
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module mant_mult
(
  input  logic                 clk,
  input  logic                 rst,

  // Operand stream
  input  logic                 in_valid,
  output logic                 in_ready,
  input  mant_mult_pkg::mant_t mant_a,
  input  mant_mult_pkg::mant_t mant_b,

  // Product stream
  output logic                 out_valid,
  input  logic                 out_ready,
  output mant_mult_pkg::prod_t product
);

  mant_mult_pkg::pp_array_t pp_comb;    // Booth rows before stage 1
  mant_mult_pkg::pp_array_t pp_q;       // Booth rows held in stage 1
  logic                     pp_valid;
  logic                     pp_ready;   // Stage 2 can take a row set
  mant_mult_pkg::prod_t     prod_comb;  // Tree output before stage 2

  //////////////////////////////////////////////////////////////////////
  // Stage 1 with Booth rows
  //////////////////////////////////////////////////////////////////////

  pp_generation pp_generation_i
  (
    .mant_a (mant_a),
    .mant_b (mant_b),
    .pp     (pp_comb)
  );

  pipe_stage #(
    .payload_t (mant_mult_pkg::pp_array_t)
  ) pp_stage_i
  (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (pp_comb),
    .out_valid (pp_valid),
    .out_ready (pp_ready),
    .out_data  (pp_q)
  );

  //////////////////////////////////////////////////////////////////////
  // Stage 2 with the reduced product
  //////////////////////////////////////////////////////////////////////

  pp_reduction pp_reduction_i
  (
    .pp      (pp_q),
    .product (prod_comb)
  );

  pipe_stage #(
    .payload_t (mant_mult_pkg::prod_t)
  ) prod_stage_i
  (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (pp_valid),
    .in_ready  (pp_ready),
    .in_data   (prod_comb),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (product)
  );

endmodule

// File: testbench/clock_gen.sv
//////////////////////////////////////////////////////////////////////
// Free-running testbench clock, starts low at time zero
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module clock_gen #(
  parameter real period_ns = 8.0
)
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(period_ns / 2.0) clk = ~clk;  // Half period per phase
    end
  end

endmodule

// File: testbench/mant_mult_tb.sv
//////////////////////////////////////////////////////////////////////
// Vectors come from testbench/mant_mult_golden.txt; run from project root
// Last burst_len vectors run with out_ready held high
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

`include "mant_mult_defines.svh"

module mant_mult_tb;

  localparam int num_vec        = 24;                       // Lines of data in the file
  localparam int burst_len      = 8;                        // Back-to-back tail
  localparam int reset_cycles   = 10;
  localparam int timeout_cycles = (num_vec + 4) * 8 + 20;

  logic                 clk;
  logic                 rst;
  logic                 in_valid;
  logic                 in_ready;
  mant_mult_pkg::mant_t mant_a;
  mant_mult_pkg::mant_t mant_b;
  logic                 out_valid;
  logic                 out_ready;
  mant_mult_pkg::prod_t product;

  // Three words per vector: a, b, a*b
  logic [`PROD_W-1:0] golden_mem [3*num_vec];
  int                 accept_cycle [num_vec];  // Loop cycle of each input transfer
  int                 in_idx = 0;              // Next vector to send
  int                 out_idx = 0;             // Next product to check
  int                 cycle_cnt = 0;           // Clock edges since time zero

  clock_gen #(
    .period_ns (8.0)
  ) clock_gen_i
  (
    .clk (clk)
  );

  mant_mult dut_i
  (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .mant_a    (mant_a),
    .mant_b    (mant_b),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .product   (product)
  );

  task automatic compare_value(input string name, input logic [`PROD_W-1:0] actual,
                               input logic [`PROD_W-1:0] expected);
    if (actual !== expected)
    begin
      $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("Some tests failed");
      $fatal(1, "Stopped at the first error");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles)
    begin
      $display("Timeout after %0d cycles, %0d of %0d products checked",
               cycle_cnt, out_idx, num_vec);
      $display("Some tests failed");
      $fatal(1, "Simulation did not finish in time");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus and checking
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int                   seed;
    int                   rnd;
    int                   cycle;
    logic                 in_fire;
    logic                 out_fire;
    logic                 hold_valid;       // Output was stalled last cycle
    mant_mult_pkg::prod_t held_product;

    rst       = 1'b1;
    in_valid  = 1'b0;
    mant_a    = '0;
    mant_b    = '0;
    out_ready = 1'b0;
    seed       = 18276;
    cycle      = 0;
    hold_valid = 1'b0;
    held_product = '0;
    $readmemh("testbench/mant_mult_golden.txt", golden_mem);

    // Stages empty while reset is held
    repeat (reset_cycles)
    begin
      @(negedge clk);
      compare_value("out_valid", `PROD_W'(out_valid), `PROD_W'(0));
      compare_value("in_ready", `PROD_W'(in_ready), `PROD_W'(1));
    end
    rst = 1'b0;

    while (out_idx < num_vec)
    begin
      rnd = $random(seed);
      out_ready = (in_idx >= num_vec - burst_len) ? 1'b1 : rnd[0];
      in_valid  = (in_idx < num_vec);
      if (in_idx < num_vec)
      begin
        mant_a = golden_mem[3*in_idx][`MANT_W-1:0];   // Held until it transfers
        mant_b = golden_mem[3*in_idx+1][`MANT_W-1:0];
      end
      #1;  // Let in_ready settle on the new out_ready

      if (cycle == 0)
      begin
        compare_value("out_valid", `PROD_W'(out_valid), `PROD_W'(0));
        compare_value("in_ready", `PROD_W'(in_ready), `PROD_W'(1));
      end

      // Stalled product must not move
      if (hold_valid)
      begin
        compare_value("out_valid", `PROD_W'(out_valid), `PROD_W'(1));
        compare_value("product", product, held_product);
      end
      hold_valid   = out_valid && !out_ready;
      held_product = product;

      in_fire  = in_valid && in_ready;
      out_fire = out_valid && out_ready;

      if (in_fire)
      begin
        accept_cycle[in_idx] = cycle;
        if (in_idx > num_vec - burst_len)  // Back to back in the burst
        begin
          compare_value("accept gap", `PROD_W'(cycle - accept_cycle[in_idx-1]), `PROD_W'(1));
        end
      end

      if (out_fire)
      begin
        compare_value("product", product, golden_mem[3*out_idx+2]);
        if (out_idx >= num_vec - burst_len)
        begin
          compare_value("latency", `PROD_W'(cycle - accept_cycle[out_idx]), `PROD_W'(2));
        end
      end

      @(negedge clk);  // Transfers happened on the edge in between
      cycle++;
      if (in_fire)
      begin
        in_idx++;
      end
      if (out_fire)
      begin
        out_idx++;
      end
    end

    // No extra products after the last one
    repeat (3)
    begin
      out_ready = 1'b1;
      in_valid  = 1'b0;
      #1;
      compare_value("out_valid", `PROD_W'(out_valid), `PROD_W'(0));
      @(negedge clk);
    end

    $display("All tests passed");
    $finish;
  end

endmodule

// File: testbench/mant_mult_golden.txt
// Columns: operand a, operand b, expected product a*b (hex)
// Zeros, one, hidden bit, all ones, and Booth patterns in operand b
000000 000000 000000000000
000000 FFFFFF 000000000000
FFFFFF 000000 000000000000
000001 000001 000000000001
800000 800000 400000000000
FFFFFF FFFFFF FFFFFE000001
FFFFFF 000001 000000FFFFFF
FFFFFF 000002 000001FFFFFE
FFFFFF 000003 000002FFFFFD
FFFFFF 000006 000005FFFFFA
FFFFFF 555555 555554AAAAAB
FFFFFF AAAAAA AAAAA9555556
FFFFFF 333333 333332CCCCCD
FFFFFF 7FFFFE 7FFFFD800002
FFFFFF 0F0F0F 0F0F0EF0F0F1
FFFFFF CCCCCC CCCCCB333334
FFFFFF 800001 8000007FFFFF
800000 555555 2AAAAA800000
800000 AAAAAA 555555000000
800000 FFFFFF 7FFFFF800000
ABCDEF 000002 000001579BDE
ABCDEF 000003 0000020369CD
ABCDEF 000004 000002AF37BC
000001 ABCDEF 000000ABCDEF

// File: files.f
+incdir+verilog
verilog/mant_mult_pkg.sv
verilog/booth_row.sv
verilog/pp_generation.sv
verilog/pp_reduction.sv
verilog/pipe_stage.sv
verilog/mant_mult.sv
testbench/clock_gen.sv
testbench/mant_mult_tb.sv

// File: Makefile
# Verilator build and run of the mantissa multiplier testbench
# Run from the project root; the testbench reads its golden file from here

.PHONY: all compile run clean

all: run

# Build the simulation binary with assertions enabled
compile:
	verilator --binary --timing --assert -f files.f --top-module mant_mult_tb

# A $fatal in the testbench gives a nonzero exit status
run: compile
	./obj_dir/Vmant_mult_tb

clean:
	rm -rf obj_dir
